// File: rtl/pr_pkg.sv
package pr_pkg;

	// Field widths
	localparam int VERTEX_ID_BITS  = 16;
	localparam int EDGE_INDEX_BITS = 16;
	localparam int DEGREE_BITS     = 8;
	localparam int DATA_BITS       = 32;

	// Buffer depths, all powers of two
	localparam int VERTEX_QUEUE_DEPTH = 4;
	localparam int EDGE_BUF_DEPTH     = 8;
	localparam int CMD_FIFO_DEPTH     = 4;

	localparam int VQ_PTR_BITS   = $clog2(VERTEX_QUEUE_DEPTH);
	localparam int EDGE_PTR_BITS = $clog2(EDGE_BUF_DEPTH);
	localparam int CMD_PTR_BITS  = $clog2(CMD_FIFO_DEPTH);

	// One vertex job, 40 bits
	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0]  vertex_id;
		logic [EDGE_INDEX_BITS-1:0] edge_start;
		logic [DEGREE_BITS-1:0]     degree;
	} vertex_job_t;

	// Tags a read command and its response
	typedef enum logic [0:0] {
		RD_EDGE_DEST  = 1'b0,
		RD_GRAPH_DATA = 1'b1
	} rd_kind_e;

	// Edge index or vertex id, used as is
	typedef logic [15:0] rd_addr_t;

endpackage

// File: rtl/pr_cmd_if.sv
`timescale 1ns/100ps

interface pr_cmd_if;
	import pr_pkg::*;

	logic     req;
	logic     ack;
	rd_kind_e kind;
	rd_addr_t addr;

	// Requesting unit
	modport source (
		output req,
		output kind,
		output addr,
		input  ack
	);

	// Read port side
	modport sink (
		input  req,
		input  kind,
		input  addr,
		output ack
	);

endinterface

// File: rtl/vertex_queue.sv
`timescale 1ns/100ps

module vertex_queue (
	input  logic                clock,
	input  logic                rstn,
	input  logic                vertex_req,
	output logic                vertex_ack,
	input  pr_pkg::vertex_job_t vertex_job,
	input  logic                done,
	output logic                active,
	output pr_pkg::vertex_job_t job
);
	import pr_pkg::*;

	vertex_job_t            job_mem [VERTEX_QUEUE_DEPTH];
	logic [VQ_PTR_BITS-1:0] wr_ptr;
	logic [VQ_PTR_BITS-1:0] rd_ptr;
	logic [VQ_PTR_BITS:0]   count;
	logic                   full;
	logic                   push;
	logic                   pop;

	assign full = (count == VERTEX_QUEUE_DEPTH);
	assign push = vertex_req && !vertex_ack && !full;
	// Head becomes active once the previous job is gone
	assign pop  = !done && !active && (count != 0);

////////////////////////////////////////////////////////////////////////////
// Job handshake
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_ack <= 1'b0;
		end else if (push) begin
			vertex_ack <= 1'b1;
		end else if (!vertex_req) begin
			vertex_ack <= 1'b0;
		end
	end

////////////////////////////////////////////////////////////////////////////
// Job FIFO
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			job_mem[wr_ptr] <= vertex_job;
		end
	end

	// Active job, held until done
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active <= 1'b0;
		end else if (done) begin
			active <= 1'b0;
		end else if (pop) begin
			active <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			job <= job_mem[rd_ptr];
		end
	end

endmodule

// File: rtl/edge_job_ctrl.sv
`timescale 1ns/100ps

module edge_job_ctrl (
	input  logic                clock,
	input  logic                rstn,
	input  logic                active,
	input  pr_pkg::vertex_job_t job,
	input  logic                edge_rsp,
	input  logic                credit_free,
	pr_cmd_if.source            cmd
);
	import pr_pkg::*;

	logic                   loaded;
	rd_addr_t               next_index;
	logic [DEGREE_BITS-1:0] remaining;
	logic [EDGE_PTR_BITS:0] outstanding;
	logic [EDGE_PTR_BITS:0] held;
	logic                   room;
	logic                   issue;

	// Reads in flight plus ids waiting must fit in the id buffer
	assign room  = (outstanding + held) < EDGE_BUF_DEPTH;
	assign issue = loaded && (remaining != 0) && !cmd.req && !cmd.ack && room;

	assign cmd.kind = RD_EDGE_DEST;

////////////////////////////////////////////////////////////////////////////
// Edge walk
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			loaded     <= 1'b0;
			next_index <= '0;
			remaining  <= '0;
		end else if (!active) begin
			loaded <= 1'b0;
		end else if (!loaded) begin
			loaded     <= 1'b1;
			next_index <= job.edge_start;
			remaining  <= job.degree;
		end else if (issue) begin
			next_index <= next_index + 1'b1;
			remaining  <= remaining - 1'b1;
		end
	end

	// Four-phase request towards the read port
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd.req <= 1'b0;
		end else if (issue) begin
			cmd.req <= 1'b1;
		end else if (cmd.ack) begin
			cmd.req <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			cmd.addr <= next_index;
		end
	end

////////////////////////////////////////////////////////////////////////////
// Credit bookkeeping
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
			held        <= '0;
		end else begin
			case ({issue, edge_rsp})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
			// An id moves from in flight to buffered, then leaves
			case ({edge_rsp, credit_free})
				2'b10:   held <= held + 1'b1;
				2'b01:   held <= held - 1'b1;
				default: held <= held;
			endcase
		end
	end

endmodule

// File: rtl/edge_data_ctrl.sv
`timescale 1ns/100ps

module edge_data_ctrl (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              dest_valid,
	input  logic [pr_pkg::VERTEX_ID_BITS-1:0] dest_id,
	output logic                              credit_free,
	pr_cmd_if.source                          cmd
);
	import pr_pkg::*;

	logic [VERTEX_ID_BITS-1:0] id_mem [EDGE_BUF_DEPTH];
	logic [EDGE_PTR_BITS-1:0]  wr_ptr;
	logic [EDGE_PTR_BITS-1:0]  rd_ptr;
	logic [EDGE_PTR_BITS:0]    count;
	logic                      pop;

	// Next id leaves the buffer as its graph read starts
	assign pop = (count != 0) && !cmd.req && !cmd.ack;

	assign cmd.kind = RD_GRAPH_DATA;

	// Credits keep dest_valid from ever finding the buffer full
	always_ff @(posedge clock) begin
		if (dest_valid) begin
			id_mem[wr_ptr] <= dest_id;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (dest_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({dest_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Request and one returned credit per id
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd.req     <= 1'b0;
			credit_free <= 1'b0;
		end else begin
			credit_free <= pop;
			if (pop) begin
				cmd.req <= 1'b1;
			end else if (cmd.ack) begin
				cmd.req <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			cmd.addr <= id_mem[rd_ptr];
		end
	end

endmodule

// File: rtl/sum_kernel.sv
`timescale 1ns/100ps

module sum_kernel (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              active,
	input  pr_pkg::vertex_job_t               job,
	input  logic                              data_valid,
	input  logic [pr_pkg::DATA_BITS-1:0]      data,
	output logic                              done,
	output logic                              wr_req,
	input  logic                              wr_ack,
	output logic [pr_pkg::VERTEX_ID_BITS-1:0] wr_vertex,
	output logic [pr_pkg::DATA_BITS-1:0]      wr_sum,
	output logic [15:0]                       vertex_count,
	output logic [31:0]                       edge_count
);
	import pr_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACCUM,
		S_WRITE,
		S_RELEASE
	} state_e;

	state_e                 state;
	logic [DEGREE_BITS-1:0] got;
	logic [DATA_BITS-1:0]   acc;

	assign wr_vertex = job.vertex_id;
	assign wr_sum    = acc;

////////////////////////////////////////////////////////////////////////////
// Accumulate and write
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= S_IDLE;
			got          <= '0;
			acc          <= '0;
			wr_req       <= 1'b0;
			done         <= 1'b0;
			vertex_count <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					// done still high means active has not dropped yet
					if (active && !done) begin
						acc <= '0;
						got <= '0;
						if (job.degree == 0) begin
							wr_req <= 1'b1;
							state  <= S_WRITE;
						end else begin
							state <= S_ACCUM;
						end
					end
				end
				S_ACCUM: begin
					if (data_valid) begin
						acc <= acc + data;
						got <= got + 1'b1;
						if ((got + 1'b1) == job.degree) begin
							wr_req <= 1'b1;
							state  <= S_WRITE;
						end
					end
				end
				S_WRITE: begin
					if (wr_ack) begin
						wr_req       <= 1'b0;
						vertex_count <= vertex_count + 1'b1;
						state        <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (!wr_ack) begin
						done  <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// One per data value returned
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count <= '0;
		end else if (data_valid) begin
			edge_count <= edge_count + 1'b1;
		end
	end

endmodule

// File: rtl/mem_read_port.sv
`timescale 1ns/100ps

module mem_read_port (
	input  logic                              clock,
	input  logic                              rstn,
	pr_cmd_if.sink                            edge_cmd,
	pr_cmd_if.sink                            data_cmd,
	output logic                              rd_cmd_req,
	input  logic                              rd_cmd_ack,
	output pr_pkg::rd_kind_e                  rd_cmd_kind,
	output pr_pkg::rd_addr_t                  rd_cmd_addr,
	input  logic                              rd_rsp_valid,
	input  pr_pkg::rd_kind_e                  rd_rsp_kind,
	input  logic [pr_pkg::DATA_BITS-1:0]      rd_rsp_data,
	output logic                              dest_valid,
	output logic [pr_pkg::VERTEX_ID_BITS-1:0] dest_id,
	output logic                              data_valid,
	output logic [pr_pkg::DATA_BITS-1:0]      data
);
	import pr_pkg::*;

	rd_kind_e              kind_mem [CMD_FIFO_DEPTH];
	rd_addr_t              addr_mem [CMD_FIFO_DEPTH];
	logic [CMD_PTR_BITS-1:0] wr_ptr;
	logic [CMD_PTR_BITS-1:0] rd_ptr;
	logic [CMD_PTR_BITS:0]   count;
	logic                  full;
	logic                  push;
	logic                  pop;
	logic                  edge_pend;
	logic                  data_pend;
	logic                  grant_edge;
	logic                  grant_data;
	logic                  last_data;
	rd_kind_e              push_kind;
	rd_addr_t              push_addr;

////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter
////////////////////////////////////////////////////////////////////////////

	// A source with ack already high has been served
	assign edge_pend = edge_cmd.req && !edge_cmd.ack;
	assign data_pend = data_cmd.req && !data_cmd.ack;

	assign full       = (count == CMD_FIFO_DEPTH);
	assign grant_data = !full && data_pend && (!edge_pend || !last_data);
	assign grant_edge = !full && edge_pend && !grant_data;
	assign push       = grant_edge || grant_data;
	assign push_kind  = grant_data ? data_cmd.kind : edge_cmd.kind;
	assign push_addr  = grant_data ? data_cmd.addr : edge_cmd.addr;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_data    <= 1'b0;
			edge_cmd.ack <= 1'b0;
			data_cmd.ack <= 1'b0;
		end else begin
			if (push) begin
				last_data <= grant_data;
			end
			if (grant_edge) begin
				edge_cmd.ack <= 1'b1;
			end else if (!edge_cmd.req) begin
				edge_cmd.ack <= 1'b0;
			end
			if (grant_data) begin
				data_cmd.ack <= 1'b1;
			end else if (!data_cmd.req) begin
				data_cmd.ack <= 1'b0;
			end
		end
	end

////////////////////////////////////////////////////////////////////////////
// Command FIFO and external handshake
////////////////////////////////////////////////////////////////////////////

	assign pop = rd_cmd_req && rd_cmd_ack;

	always_ff @(posedge clock) begin
		if (push) begin
			kind_mem[wr_ptr] <= push_kind;
			addr_mem[wr_ptr] <= push_addr;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry stays put until its ack pops it
	assign rd_cmd_kind = kind_mem[rd_ptr];
	assign rd_cmd_addr = addr_mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_cmd_req <= 1'b0;
		end else if (pop) begin
			rd_cmd_req <= 1'b0;
		end else if (!rd_cmd_req && !rd_cmd_ack && (count != 0)) begin
			rd_cmd_req <= 1'b1;
		end
	end

////////////////////////////////////////////////////////////////////////////
// Response router
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			dest_valid <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			dest_valid <= 1'b0;
			data_valid <= 1'b0;
			if (rd_rsp_valid) begin
				case (rd_rsp_kind)
					RD_EDGE_DEST:  dest_valid <= 1'b1;
					RD_GRAPH_DATA: data_valid <= 1'b1;
					default:       dest_valid <= 1'b0;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_rsp_valid) begin
			dest_id <= rd_rsp_data[VERTEX_ID_BITS-1:0];
			data    <= rd_rsp_data;
		end
	end

endmodule

// File: rtl/pr_vertex_cu.sv
`timescale 1ns/100ps

module pr_vertex_cu (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               vertex_req,
	output logic                               vertex_ack,
	input  logic [pr_pkg::VERTEX_ID_BITS-1:0]  vertex_id,
	input  logic [pr_pkg::EDGE_INDEX_BITS-1:0] edge_start,
	input  logic [pr_pkg::DEGREE_BITS-1:0]     degree,
	output logic                               rd_cmd_req,
	input  logic                               rd_cmd_ack,
	output pr_pkg::rd_kind_e                   rd_cmd_kind,
	output pr_pkg::rd_addr_t                   rd_cmd_addr,
	input  logic                               rd_rsp_valid,
	input  pr_pkg::rd_kind_e                   rd_rsp_kind,
	input  logic [pr_pkg::DATA_BITS-1:0]       rd_rsp_data,
	output logic                               wr_req,
	input  logic                               wr_ack,
	output logic [pr_pkg::VERTEX_ID_BITS-1:0]  wr_vertex,
	output logic [pr_pkg::DATA_BITS-1:0]       wr_sum,
	output logic [15:0]                        vertex_count,
	output logic [31:0]                        edge_count
);
	import pr_pkg::*;

	vertex_job_t               new_job;
	vertex_job_t               active_job;
	logic                      active;
	logic                      done;
	logic                      credit_free;
	logic                      dest_valid;
	logic [VERTEX_ID_BITS-1:0] dest_id;
	logic                      data_valid;
	logic [DATA_BITS-1:0]      data;

	pr_cmd_if edge_cmd ();
	pr_cmd_if data_cmd ();

	assign new_job.vertex_id  = vertex_id;
	assign new_job.edge_start = edge_start;
	assign new_job.degree     = degree;

////////////////////////////////////////////////////////////////////////////
// Units
////////////////////////////////////////////////////////////////////////////

	vertex_queue vertex_queue_i (
		.clock      (clock),
		.rstn       (rstn),
		.vertex_req (vertex_req),
		.vertex_ack (vertex_ack),
		.vertex_job (new_job),
		.done       (done),
		.active     (active),
		.job        (active_job)
	);

	// Edge responses double as the credit tracker's return pulse
	edge_job_ctrl edge_job_ctrl_i (
		.clock       (clock),
		.rstn        (rstn),
		.active      (active),
		.job         (active_job),
		.edge_rsp    (dest_valid),
		.credit_free (credit_free),
		.cmd         (edge_cmd.source)
	);

	edge_data_ctrl edge_data_ctrl_i (
		.clock       (clock),
		.rstn        (rstn),
		.dest_valid  (dest_valid),
		.dest_id     (dest_id),
		.credit_free (credit_free),
		.cmd         (data_cmd.source)
	);

	sum_kernel sum_kernel_i (
		.clock        (clock),
		.rstn         (rstn),
		.active       (active),
		.job          (active_job),
		.data_valid   (data_valid),
		.data         (data),
		.done         (done),
		.wr_req       (wr_req),
		.wr_ack       (wr_ack),
		.wr_vertex    (wr_vertex),
		.wr_sum       (wr_sum),
		.vertex_count (vertex_count),
		.edge_count   (edge_count)
	);

	mem_read_port mem_read_port_i (
		.clock        (clock),
		.rstn         (rstn),
		.edge_cmd     (edge_cmd.sink),
		.data_cmd     (data_cmd.sink),
		.rd_cmd_req   (rd_cmd_req),
		.rd_cmd_ack   (rd_cmd_ack),
		.rd_cmd_kind  (rd_cmd_kind),
		.rd_cmd_addr  (rd_cmd_addr),
		.rd_rsp_valid (rd_rsp_valid),
		.rd_rsp_kind  (rd_rsp_kind),
		.rd_rsp_data  (rd_rsp_data),
		.dest_valid   (dest_valid),
		.dest_id      (dest_id),
		.data_valid   (data_valid),
		.data         (data)
	);

endmodule

// File: tb/pr_mem_model.sv
`timescale 1ns/100ps

module pr_mem_model (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         rd_cmd_req,
	output logic                         rd_cmd_ack,
	input  pr_pkg::rd_kind_e             rd_cmd_kind,
	input  pr_pkg::rd_addr_t             rd_cmd_addr,
	output logic                         rd_rsp_valid,
	output pr_pkg::rd_kind_e             rd_rsp_kind,
	output logic [pr_pkg::DATA_BITS-1:0] rd_rsp_data
);
	import pr_pkg::*;

	rd_kind_e kind_q [$];
	rd_addr_t addr_q [$];
	int       due_q [$];
	int       cycle;
	int       last_due;
	int       due;

	// Edge array and graph data contents
	function automatic logic [DATA_BITS-1:0] read_word(input rd_kind_e kind, input rd_addr_t addr);
		logic [31:0] index;
		index = {16'b0, addr};
		if (kind == RD_EDGE_DEST) begin
			return (index * 7 + 3) % 64;
		end else begin
			return index * 32'h0100_0193 + 32'h55;
		end
	endfunction

	initial begin
		rd_cmd_ack   = 1'b0;
		rd_rsp_valid = 1'b0;
		rd_rsp_kind  = RD_EDGE_DEST;
		rd_rsp_data  = '0;
		cycle        = 0;
		last_due     = 0;
	end

	always @(negedge clock) begin
		if (!rstn) begin
			rd_cmd_ack   <= 1'b0;
			rd_rsp_valid <= 1'b0;
			kind_q.delete();
			addr_q.delete();
			due_q.delete();
			cycle    = 0;
			last_due = 0;
		end else begin
			cycle = cycle + 1;
			// Four-phase command acceptance
			if (rd_cmd_req && !rd_cmd_ack) begin
				rd_cmd_ack <= 1'b1;
				due = cycle + 1 + int'($urandom % 6);
				// Keep answers in order, one per cycle
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				kind_q.push_back(rd_cmd_kind);
				addr_q.push_back(rd_cmd_addr);
				due_q.push_back(due);
			end else if (!rd_cmd_req) begin
				rd_cmd_ack <= 1'b0;
			end
			rd_rsp_valid <= 1'b0;
			if ((due_q.size() != 0) && (due_q[0] <= cycle)) begin
				rd_rsp_valid <= 1'b1;
				rd_rsp_kind  <= kind_q[0];
				rd_rsp_data  <= read_word(kind_q[0], addr_q[0]);
				void'(kind_q.pop_front());
				void'(addr_q.pop_front());
				void'(due_q.pop_front());
			end
		end
	end

endmodule

// File: tb/tb_pr_vertex_cu.sv
`timescale 1ns/100ps

module tb_pr_vertex_cu;
	import pr_pkg::*;

	localparam logic [31:0] SEED            = 32'h3b60_d894;
	localparam int          RANDOM_JOBS     = 40;
	localparam int          MAX_RAND_DEGREE = 48;
	localparam int          WATCHDOG_CYCLES = 40 * 64 * 20;

	logic                       clock;
	logic                       rstn;
	logic                       vertex_req;
	logic                       vertex_ack;
	logic [VERTEX_ID_BITS-1:0]  vertex_id;
	logic [EDGE_INDEX_BITS-1:0] edge_start;
	logic [DEGREE_BITS-1:0]     degree;
	logic                       rd_cmd_req;
	logic                       rd_cmd_ack;
	rd_kind_e                   rd_cmd_kind;
	rd_addr_t                   rd_cmd_addr;
	logic                       rd_rsp_valid;
	rd_kind_e                   rd_rsp_kind;
	logic [DATA_BITS-1:0]       rd_rsp_data;
	logic                       wr_req;
	logic                       wr_ack;
	logic [VERTEX_ID_BITS-1:0]  wr_vertex;
	logic [DATA_BITS-1:0]       wr_sum;
	logic [15:0]                vertex_count;
	logic [31:0]                edge_count;

	vertex_job_t exp_q [$];
	vertex_job_t exp_job;
	rd_addr_t    edge_addr_q [$];
	rd_addr_t    data_addr_q [$];
	rd_addr_t    exp_addr;
	int          errors;
	int          checks;
	int          stalls;
	int          total_jobs;
	int          total_edges;

	pr_vertex_cu dut_i (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_req   (vertex_req),
		.vertex_ack   (vertex_ack),
		.vertex_id    (vertex_id),
		.edge_start   (edge_start),
		.degree       (degree),
		.rd_cmd_req   (rd_cmd_req),
		.rd_cmd_ack   (rd_cmd_ack),
		.rd_cmd_kind  (rd_cmd_kind),
		.rd_cmd_addr  (rd_cmd_addr),
		.rd_rsp_valid (rd_rsp_valid),
		.rd_rsp_kind  (rd_rsp_kind),
		.rd_rsp_data  (rd_rsp_data),
		.wr_req       (wr_req),
		.wr_ack       (wr_ack),
		.wr_vertex    (wr_vertex),
		.wr_sum       (wr_sum),
		.vertex_count (vertex_count),
		.edge_count   (edge_count)
	);

	pr_mem_model mem_i (
		.clock        (clock),
		.rstn         (rstn),
		.rd_cmd_req   (rd_cmd_req),
		.rd_cmd_ack   (rd_cmd_ack),
		.rd_cmd_kind  (rd_cmd_kind),
		.rd_cmd_addr  (rd_cmd_addr),
		.rd_rsp_valid (rd_rsp_valid),
		.rd_rsp_kind  (rd_rsp_kind),
		.rd_rsp_data  (rd_rsp_data)
	);

	always #5 clock = ~clock;

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] edge_dest(input logic [EDGE_INDEX_BITS-1:0] index);
		return ({16'b0, index} * 7 + 3) % 64;
	endfunction

	function automatic logic [31:0] vertex_data(input logic [31:0] v);
		return v * 32'h0100_0193 + 32'h55;
	endfunction

	// Sum over the vertex's edges with a 16-bit index wrap
	function automatic logic [31:0] expected_sum(input logic [EDGE_INDEX_BITS-1:0] start,
		input logic [DEGREE_BITS-1:0] deg);
		logic [31:0]                sum;
		logic [EDGE_INDEX_BITS-1:0] index;
		sum   = '0;
		index = start;
		for (int k = 0; k < deg; k++) begin
			sum   = sum + vertex_data(edge_dest(index));
			index = index + 1'b1;
		end
		return sum;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////////////////////

	// Starts and ends on a falling edge
	task automatic send_job(input logic [VERTEX_ID_BITS-1:0] vid,
		input logic [EDGE_INDEX_BITS-1:0] start, input logic [DEGREE_BITS-1:0] deg);
		vertex_job_t job;
		rd_addr_t    index;
		int          waited;
		job.vertex_id  = vid;
		job.edge_start = start;
		job.degree     = deg;
		exp_q.push_back(job);
		// Read addresses this job should produce
		index = start;
		for (int k = 0; k < deg; k++) begin
			edge_addr_q.push_back(index);
			data_addr_q.push_back(rd_addr_t'(edge_dest(index)));
			index = index + 1'b1;
		end
		total_jobs++;
		total_edges += deg;
		vertex_id  = vid;
		edge_start = start;
		degree     = deg;
		vertex_req = 1'b1;
		waited     = 0;
		@(negedge clock);
		while (!vertex_ack) begin
			waited++;
			@(negedge clock);
		end
		if (waited > 0) begin
			stalls++;
		end
		vertex_req = 1'b0;
		@(negedge clock);
		while (vertex_ack) begin
			@(negedge clock);
		end
	endtask

	task automatic wait_idle();
		while ((exp_q.size() != 0) || wr_req || wr_ack) begin
			@(negedge clock);
		end
	endtask

////////////////////////////////////////////////////////////////////////////
// Write responder and compare
////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn) begin
			if (wr_req && !wr_ack) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Write for vertex 0x%h arrived with no job pending", wr_vertex);
				end else begin
					exp_job = exp_q.pop_front();
					check_value("wr_vertex", wr_vertex, exp_job.vertex_id);
					check_value("wr_sum", wr_sum,
						expected_sum(exp_job.edge_start, exp_job.degree));
				end
				wr_ack <= 1'b1;
			end else if (!wr_req && wr_ack) begin
				wr_ack <= 1'b0;
			end
		end
	end

	// Each accepted read command against the expected address order
	always @(negedge clock) begin
		if (rstn && rd_cmd_req && !rd_cmd_ack) begin
			if (rd_cmd_kind == RD_EDGE_DEST) begin
				if (edge_addr_q.size() == 0) begin
					errors++;
					$display("Edge read at 0x%h issued with no edge left to read",
						rd_cmd_addr);
				end else begin
					exp_addr = edge_addr_q.pop_front();
					check_value("rd_cmd_addr", rd_cmd_addr, exp_addr);
				end
			end else if (data_addr_q.size() == 0) begin
				errors++;
				$display("Graph read at 0x%h issued with no destination pending",
					rd_cmd_addr);
			end else begin
				exp_addr = data_addr_q.pop_front();
				check_value("rd_cmd_addr", rd_cmd_addr, exp_addr);
			end
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

////////////////////////////////////////////////////////////////////////////
// Main sequence
////////////////////////////////////////////////////////////////////////////

	initial begin
		clock       = 1'b0;
		rstn        = 1'b0;
		vertex_req  = 1'b0;
		vertex_id   = '0;
		edge_start  = '0;
		degree      = '0;
		wr_ack      = 1'b0;
		errors      = 0;
		checks      = 0;
		stalls      = 0;
		total_jobs  = 0;
		total_edges = 0;
		void'($urandom(SEED));
		repeat (2) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);

		// Idle outputs after reset
		check_value("vertex_ack", vertex_ack, 0);
		check_value("rd_cmd_req", rd_cmd_req, 0);
		check_value("wr_req", wr_req, 0);
		check_value("vertex_count", vertex_count, 0);
		check_value("edge_count", edge_count, 0);

		send_job(16'h0101, 16'h0010, 8'd5);
		wait_idle();
		send_job(16'h0202, 16'h0020, 8'd0);
		wait_idle();

		// Back to back so the queue fills
		stalls = 0;
		for (int n = 0; n < RANDOM_JOBS; n++) begin
			send_job(16'($urandom), 16'($urandom), 8'($urandom % (MAX_RAND_DEGREE + 1)));
		end
		wait_idle();
		if (stalls == 0) begin
			errors++;
			$display("vertex_ack never stalled while jobs were sent back to back");
		end

		// More edges than the id buffer holds
		send_job(16'h0404, 16'hfff0, 8'd40);
		wait_idle();

		repeat (4) @(negedge clock);
		check_value("vertex_count", vertex_count, total_jobs);
		check_value("edge_count", edge_count, total_edges);

		$display("Jobs: %0d, checks: %0d, errors: %0d", total_jobs, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: list.f
rtl/pr_pkg.sv
rtl/pr_cmd_if.sv
rtl/vertex_queue.sv
rtl/edge_job_ctrl.sv
rtl/edge_data_ctrl.sv
rtl/sum_kernel.sv
rtl/mem_read_port.sv
rtl/pr_vertex_cu.sv
tb/pr_mem_model.sv
tb/tb_pr_vertex_cu.sv
